// File: logic/vp_cfg.svh
`ifndef VP_CFG_SVH
`define VP_CFG_SVH

// Core identity on the shared buses
`define VP_CORE_ID          7'd0

`define VP_MATRIX_WORDS     16
`define VP_FACE_WORDS       24
`define VP_WORDS_PER_VERTEX 8   // pos xyz, uv, normal xyz

`define VP_FRAC_BITS        16  // Q16.16
`define VP_OP_MODELVIEW     3'd1

// Fixed view direction, Q16.16
`define VP_VIEW_X           32'sh0000_0000  // 0.0
`define VP_VIEW_Y           32'shFFFF_8000  // -0.5
`define VP_VIEW_Z           32'shFFFF_0000  // -1.0
`define VP_ONE              32'sh0001_0000

`endif

// File: logic/vp_pkg.sv
`include "vp_cfg.svh"

package vp_pkg;

    typedef logic signed [31:0] fix_t;     // Q16.16
    typedef fix_t [2:0]         vec3_t;    // x in element 0
    typedef fix_t [1:0]         vec2_t;    // u, v
    typedef fix_t [15:0]        mat4_t;    // Row-major, row*4 + col
    typedef vec3_t [2:0]        tri_pos_t;
    typedef vec2_t [2:0]        tri_uv_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        REQUEST_FACE,
        RECEIVE_FACE,
        TRANSFORM,
        CULL,
        OUTPUT
    } seq_state_t;

    // Full product, then drop the extra fraction bits
    function automatic fix_t fx_mul(input fix_t a, input fix_t b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return fix_t'(prod >>> `VP_FRAC_BITS);
    endfunction

endpackage

// File: logic/xform_if.sv
`timescale 1ns/10ps

// Face positions into the view transform, view positions out
interface xform_if;

    logic               start;  // One-cycle pulse
    vp_pkg::tri_pos_t   pos;    // Held from start to done
    logic               done;   // One-cycle pulse
    vp_pkg::tri_pos_t   view;

    modport source (
        output pos
    );

    modport ctrl (
        output start,
        input  done
    );

    modport unit (
        input  start,
        input  pos,
        output view,
        output done
    );

    modport sink (
        input  view
    );

endinterface

// File: logic/matrix_loader.sv
`timescale 1ns/10ps
`include "vp_cfg.svh"

module matrix_loader (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_start,
    input  vp_pkg::fix_t        matrix_data,
    input  logic [6:0]          matrix_target_core_id,
    input  logic                matrix_valid,
    output logic                matrix_request,
    output logic [2:0]          matrix_opcode,
    output logic                matrix_read_done,
    output logic                load_done,
    output vp_pkg::mat4_t       mv
);

    logic       waiting;    // Between request and last word
    logic [3:0] word_cnt;
    logic       accept;

    assign accept = waiting && matrix_valid && (matrix_target_core_id == `VP_CORE_ID);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            matrix_request   <= 1'b0;
            matrix_opcode    <= 3'd0;
            matrix_read_done <= 1'b0;
            waiting          <= 1'b0;
            word_cnt         <= 4'd0;
        end else begin
            matrix_request   <= 1'b0;
            matrix_read_done <= 1'b0;
            if (load_start) begin
                matrix_request <= 1'b1;
                matrix_opcode  <= `VP_OP_MODELVIEW;  // Held after the pulse
                waiting        <= 1'b1;
                word_cnt       <= 4'd0;
            end else if (accept) begin
                word_cnt <= word_cnt + 4'd1;
                if (word_cnt == 4'(`VP_MATRIX_WORDS - 1)) begin
                    waiting          <= 1'b0;
                    matrix_read_done <= 1'b1;
                end
            end
        end
    end

    // Words come in row-major order
    always_ff @(posedge clk) begin
        if (accept) begin
            mv[word_cnt] <= matrix_data;
        end
    end

    assign load_done = matrix_read_done;

endmodule

// File: logic/face_receiver.sv
`timescale 1ns/10ps
`include "vp_cfg.svh"

module face_receiver (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                face_start,
    input  vp_pkg::fix_t        vertex_data,
    input  logic [6:0]          vertex_target_core_id,
    input  logic                vertex_valid,
    output logic                vertex_request,
    output logic                vertex_read_done,
    output logic                face_done,
    output vp_pkg::tri_uv_t     uv,
    xform_if.source             xf
);

    logic       waiting;
    logic [4:0] word_cnt;
    logic       accept;
    logic [1:0] vtx;    // Vertex of the current word
    logic [2:0] fld;    // Slot within the vertex

    assign accept = waiting && vertex_valid && (vertex_target_core_id == `VP_CORE_ID);
    assign vtx    = 2'(word_cnt / `VP_WORDS_PER_VERTEX);
    assign fld    = 3'(word_cnt % `VP_WORDS_PER_VERTEX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vertex_request   <= 1'b0;
            vertex_read_done <= 1'b0;
            waiting          <= 1'b0;
            word_cnt         <= 5'd0;
        end else begin
            vertex_request   <= face_start;
            vertex_read_done <= 1'b0;
            if (face_start) begin
                waiting  <= 1'b1;
                word_cnt <= 5'd0;
            end else if (accept) begin
                word_cnt <= word_cnt + 5'd1;
                if (word_cnt == 5'(`VP_FACE_WORDS - 1)) begin
                    waiting          <= 1'b0;
                    vertex_read_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (fld < 3'd3) begin
                xf.pos[vtx][fld[1:0]] <= vertex_data;   // Position xyz
            end else if (fld < 3'd5) begin
                uv[vtx][fld[2]] <= vertex_data;         // 3 -> u, 4 -> v
            end
            // Slots 5 to 7 hold the normal, not kept
        end
    end

    assign face_done = vertex_read_done;

endmodule

// File: logic/view_transform.sv
`timescale 1ns/10ps
`include "vp_cfg.svh"

// View position = MV * (x, y, z, 1), one component per cycle
module view_transform (
    input  logic            clk,
    input  logic            rst_n,
    input  vp_pkg::mat4_t   mv,
    xform_if.unit           xf
);

    logic               busy;
    logic [3:0]         step;       // 0..8, vertex-major
    logic [3:0]         cur_step;
    logic [1:0]         vtx;
    logic [1:0]         comp;       // Also the matrix row
    vp_pkg::vec3_t      p;
    vp_pkg::fix_t       acc;

    // Step 0 runs in the start cycle itself
    assign cur_step = xf.start ? 4'd0 : step;
    assign vtx      = 2'(cur_step / 4'd3);
    assign comp     = 2'(cur_step % 4'd3);
    assign p        = xf.pos[vtx];

    always_comb begin
        acc = vp_pkg::fx_mul(mv[{comp, 2'd0}], p[0])
            + vp_pkg::fx_mul(mv[{comp, 2'd1}], p[1])
            + vp_pkg::fx_mul(mv[{comp, 2'd2}], p[2])
            + vp_pkg::fx_mul(mv[{comp, 2'd3}], `VP_ONE);  // w = 1
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            step    <= 4'd0;
            xf.done <= 1'b0;
        end else begin
            xf.done <= 1'b0;
            if (xf.start) begin
                busy <= 1'b1;
                step <= 4'd1;
            end else if (busy) begin
                step <= step + 4'd1;
                if (step == 4'd8) begin
                    busy    <= 1'b0;
                    xf.done <= 1'b1;    // Last component lands with done
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xf.start || busy) begin
            xf.view[vtx][comp] <= acc;
        end
    end

endmodule

// File: logic/cull_unit.sv
`timescale 1ns/10ps
`include "vp_cfg.svh"

module cull_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cull_start,
    output logic        cull_done,
    output logic        keep,
    xform_if.sink       xf
);

    logic               s1_vld;
    logic               s2_vld;
    vp_pkg::vec3_t      e1;
    vp_pkg::vec3_t      e2;
    vp_pkg::vec3_t      nrm;
    vp_pkg::vec3_t      cross_prod;
    vp_pkg::fix_t       dot;

    // n[i] = e1[j]*e2[k] - e1[k]*e2[j] with j and k cycling after i
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            cross_prod[i] = vp_pkg::fx_mul(e1[(i + 1) % 3], e2[(i + 2) % 3])
                          - vp_pkg::fx_mul(e1[(i + 2) % 3], e2[(i + 1) % 3]);
        end
        dot = vp_pkg::fx_mul(nrm[0], `VP_VIEW_X)
            + vp_pkg::fx_mul(nrm[1], `VP_VIEW_Y)
            + vp_pkg::fx_mul(nrm[2], `VP_VIEW_Z);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld    <= 1'b0;
            s2_vld    <= 1'b0;
            cull_done <= 1'b0;
            keep      <= 1'b0;
        end else begin
            s1_vld    <= cull_start;
            s2_vld    <= s1_vld;
            cull_done <= s2_vld;
            if (s2_vld) begin
                keep <= ~dot[31];   // Facing the viewer
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cull_start) begin
            for (int i = 0; i < 3; i++) begin
                e1[i] <= xf.view[1][i] - xf.view[0][i];
                e2[i] <= xf.view[2][i] - xf.view[0][i];
            end
        end
        if (s1_vld) begin
            nrm <= cross_prod;
        end
    end

endmodule

// File: logic/vertex_sequencer.sv
`timescale 1ns/10ps

module vertex_sequencer (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start_render,
    input  logic    load_done,
    input  logic    face_done,
    input  logic    cull_done,
    input  logic    keep,
    output logic    load_start,
    output logic    face_start,
    output logic    cull_start,
    output logic    vertex_output_valid,
    xform_if.ctrl   xf
);

    vp_pkg::seq_state_t state;
    vp_pkg::seq_state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= vp_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            vp_pkg::IDLE: begin
                if (start_render) begin
                    state_nxt = vp_pkg::LOAD;
                end
            end
            vp_pkg::LOAD: begin
                if (load_done) begin
                    state_nxt = vp_pkg::REQUEST_FACE;
                end
            end
            vp_pkg::REQUEST_FACE: state_nxt = vp_pkg::RECEIVE_FACE;  // Request on the bus
            vp_pkg::RECEIVE_FACE: begin
                if (face_done) begin
                    state_nxt = vp_pkg::TRANSFORM;
                end
            end
            vp_pkg::TRANSFORM: begin
                if (xf.done) begin
                    state_nxt = vp_pkg::CULL;
                end
            end
            vp_pkg::CULL: begin
                if (cull_done) begin
                    state_nxt = vp_pkg::OUTPUT;
                end
            end
            vp_pkg::OUTPUT: state_nxt = vp_pkg::REQUEST_FACE;  // Matrix kept, loop on faces
            default: state_nxt = vp_pkg::IDLE;
        endcase
    end

    // Start pulses fire on the transition so each unit reacts a cycle sooner
    assign load_start          = (state == vp_pkg::IDLE) && start_render;
    assign face_start          = ((state == vp_pkg::LOAD) && load_done)
                               || (state == vp_pkg::OUTPUT);
    assign xf.start            = (state == vp_pkg::RECEIVE_FACE) && face_done;
    assign cull_start          = (state == vp_pkg::TRANSFORM) && xf.done;
    assign vertex_output_valid = (state == vp_pkg::OUTPUT) && keep;  // Culled faces stay silent

endmodule

// File: logic/vertex_processor.sv
`timescale 1ns/10ps

module vertex_processor (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_render,
    // Matrix bus
    output logic                matrix_request,
    output logic [2:0]          matrix_opcode,
    input  vp_pkg::fix_t        matrix_data,
    input  logic [6:0]          matrix_target_core_id,
    input  logic                matrix_valid,
    output logic                matrix_read_done,
    // Vertex bus
    input  vp_pkg::fix_t        vertex_data,
    input  logic [6:0]          vertex_target_core_id,
    input  logic                vertex_valid,
    output logic                vertex_request,
    output logic                vertex_read_done,
    // Toward the rasterizer
    output logic                vertex_output_valid,
    output vp_pkg::tri_pos_t    view_vert,
    output vp_pkg::tri_uv_t     uv
);

    xform_if xf ();

    logic           load_start;
    logic           load_done;
    logic           face_start;
    logic           face_done;
    logic           cull_start;
    logic           cull_done;
    logic           keep;
    vp_pkg::mat4_t  mv;

    vertex_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start_render(start_render),
        .load_done(load_done), .face_done(face_done), .cull_done(cull_done),
        .keep(keep), .load_start(load_start), .face_start(face_start),
        .cull_start(cull_start), .vertex_output_valid(vertex_output_valid), .xf(xf)
    );

    matrix_loader u_loader (
        .clk(clk), .rst_n(rst_n), .load_start(load_start),
        .matrix_data(matrix_data), .matrix_target_core_id(matrix_target_core_id),
        .matrix_valid(matrix_valid), .matrix_request(matrix_request),
        .matrix_opcode(matrix_opcode), .matrix_read_done(matrix_read_done),
        .load_done(load_done), .mv(mv)
    );

    face_receiver u_face (
        .clk(clk), .rst_n(rst_n), .face_start(face_start),
        .vertex_data(vertex_data), .vertex_target_core_id(vertex_target_core_id),
        .vertex_valid(vertex_valid), .vertex_request(vertex_request),
        .vertex_read_done(vertex_read_done), .face_done(face_done), .uv(uv), .xf(xf)
    );

    view_transform u_xform (.clk(clk), .rst_n(rst_n), .mv(mv), .xf(xf));

    cull_unit u_cull (
        .clk(clk), .rst_n(rst_n), .cull_start(cull_start),
        .cull_done(cull_done), .keep(keep), .xf(xf)
    );

    assign view_vert = xf.view;   // Stable until the next transform

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps

// Free-running testbench clock, 40 ns period
module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

// File: dv/vertex_processor_tb.sv
`timescale 1ns/10ps
`include "vp_cfg.svh"

module vertex_processor_tb;

    localparam int unsigned SEED = 32'h0a4f0aa2;
    localparam int RST_CYCLES    = 16;
    localparam int N_FACES       = 6;
    localparam int N_FRONT       = 3;
    localparam int BUS_WORDS     = `VP_MATRIX_WORDS + N_FACES * `VP_FACE_WORDS;
    localparam int BUDGET        = RST_CYCLES + 4 * BUS_WORDS + 20 * N_FACES;
    localparam int CYCLE_LIMIT   = ((2 * BUDGET + 499) / 500) * 500;  // 2000 cycles

    logic               clk;
    logic               rst_n;
    logic               start_render;
    logic               matrix_request;
    logic [2:0]         matrix_opcode;
    vp_pkg::fix_t       matrix_data;
    logic [6:0]         matrix_target_core_id;
    logic               matrix_valid;
    logic               matrix_read_done;
    vp_pkg::fix_t       vertex_data;
    logic [6:0]         vertex_target_core_id;
    logic               vertex_valid;
    logic               vertex_request;
    logic               vertex_read_done;
    logic               vertex_output_valid;
    vp_pkg::tri_pos_t   view_vert;
    vp_pkg::tri_uv_t    uv;

    // Reference data
    vp_pkg::mat4_t      mat;
    vp_pkg::tri_pos_t   face_pos [N_FACES];
    vp_pkg::tri_uv_t    face_uv [N_FACES];
    vp_pkg::tri_pos_t   exp_view [N_FACES];
    bit                 face_front [N_FACES];
    vp_pkg::fix_t       tx_q [$];

    // Monitor state updated on the rising edge
    int                 cycles = 0;
    int                 cur_face = 0;
    int                 m_cnt = 0;
    int                 v_cnt = 0;
    int                 n_valid = 0;
    logic               armed = 1'b0;
    logic               started = 1'b0;
    logic               exp_mreq = 1'b0;
    logic [2:0]         exp_op = 3'd0;
    logic               exp_mrd = 1'b0;
    logic               exp_vrd = 1'b0;
    logic               m_wait = 1'b0;
    logic               v_wait = 1'b0;
    logic               first_vreq = 1'b0;
    logic               rx = 1'b0;
    logic               pend = 1'b0;

    tb_clk_gen u_clk (.clk(clk));

    vertex_processor dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .start_render(start_render),
        .matrix_request(matrix_request),
        .matrix_opcode(matrix_opcode),
        .matrix_data(matrix_data),
        .matrix_target_core_id(matrix_target_core_id),
        .matrix_valid(matrix_valid),
        .matrix_read_done(matrix_read_done),
        .vertex_data(vertex_data),
        .vertex_target_core_id(vertex_target_core_id),
        .vertex_valid(vertex_valid),
        .vertex_request(vertex_request),
        .vertex_read_done(vertex_read_done),
        .vertex_output_valid(vertex_output_valid),
        .view_vert(view_vert),
        .uv(uv)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [287:0] exp,
                                   input logic [287:0] act);
        stop_run($sformatf("ERR %s expected 0x%0h got 0x%0h", sig, exp, act));
    endtask

    // Q16.16 product taken from bits 47..16 of the full signed product
    function automatic vp_pkg::fix_t mul_q16(input vp_pkg::fix_t a, input vp_pkg::fix_t b);
        logic signed [63:0] full;
        full = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        return full[47:16];
    endfunction

    function automatic vp_pkg::tri_pos_t view_of(input vp_pkg::mat4_t m,
                                                 input vp_pkg::tri_pos_t p);
        vp_pkg::tri_pos_t r;
        for (int v = 0; v < 3; v++) begin
            for (int row = 0; row < 3; row++) begin
                r[v][row] = mul_q16(m[row * 4], p[v][0]) + mul_q16(m[row * 4 + 1], p[v][1])
                          + mul_q16(m[row * 4 + 2], p[v][2]) + mul_q16(m[row * 4 + 3], `VP_ONE);
            end
        end
        return r;
    endfunction

    function automatic bit is_front_facing(input vp_pkg::tri_pos_t w);
        vp_pkg::fix_t e1 [3];
        vp_pkg::fix_t e2 [3];
        vp_pkg::fix_t n [3];
        vp_pkg::fix_t d;
        for (int i = 0; i < 3; i++) begin
            e1[i] = w[1][i] - w[0][i];
            e2[i] = w[2][i] - w[0][i];
        end
        n[0] = mul_q16(e1[1], e2[2]) - mul_q16(e1[2], e2[1]);
        n[1] = mul_q16(e1[2], e2[0]) - mul_q16(e1[0], e2[2]);
        n[2] = mul_q16(e1[0], e2[1]) - mul_q16(e1[1], e2[0]);
        d = mul_q16(n[0], `VP_VIEW_X) + mul_q16(n[1], `VP_VIEW_Y) + mul_q16(n[2], `VP_VIEW_Z);
        return !d[31];
    endfunction

    // Uniform Q16.16 value within plus or minus whole
    function automatic vp_pkg::fix_t random_fix(input int unsigned whole);
        return vp_pkg::fix_t'($urandom_range(0, whole << 17)) - vp_pkg::fix_t'(whole << 16);
    endfunction

    task automatic build_stimulus();
        int j;
        bit t;
        vp_pkg::tri_pos_t p;
        for (int i = 0; i < `VP_MATRIX_WORDS; i++) begin
            mat[i] = random_fix(2);
        end
        for (int i = 0; i < N_FACES; i++) begin
            face_front[i] = (i < N_FRONT);
        end
        for (int i = N_FACES - 1; i > 0; i--) begin  // Shuffle front and back faces
            j = $urandom_range(0, i);
            t = face_front[i];
            face_front[i] = face_front[j];
            face_front[j] = t;
        end
        for (int f = 0; f < N_FACES; f++) begin
            do begin  // Redraw until the face lands on the wanted side
                for (int v = 0; v < 3; v++) begin
                    for (int c = 0; c < 3; c++) begin
                        p[v][c] = random_fix(8);
                    end
                end
            end while (is_front_facing(view_of(mat, p)) != face_front[f]);
            face_pos[f] = p;
            exp_view[f] = view_of(mat, p);
            for (int v = 0; v < 3; v++) begin
                face_uv[f][v][0] = vp_pkg::fix_t'($urandom());
                face_uv[f][v][1] = vp_pkg::fix_t'($urandom());
            end
        end
    endtask

    task automatic queue_face(input int f);
        for (int v = 0; v < 3; v++) begin
            for (int c = 0; c < 3; c++) begin
                tx_q.push_back(face_pos[f][v][c]);
            end
            tx_q.push_back(face_uv[f][v][0]);
            tx_q.push_back(face_uv[f][v][1]);
            for (int c = 0; c < 3; c++) begin
                tx_q.push_back(vp_pkg::fix_t'($urandom()));  // Normal words the core drops
            end
        end
    endtask

    task automatic drive_bus(input bit to_vertex, input logic vld, input logic [6:0] id,
                             input vp_pkg::fix_t data);
        if (to_vertex) begin
            vertex_valid          <= vld;
            vertex_target_core_id <= id;
            vertex_data           <= data;
        end else begin
            matrix_valid          <= vld;
            matrix_target_core_id <= id;
            matrix_data           <= data;
        end
    endtask

    // Empties tx_q onto one bus with idle gaps and words for other cores
    task automatic send_stream(input bit to_vertex);
        while (tx_q.size() > 0) begin
            @(posedge clk);
            case ($urandom_range(0, 3))
                0: drive_bus(to_vertex, 1'b0, 7'd0, 32'sh0);
                1: drive_bus(to_vertex, 1'b1, 7'($urandom_range(1, 127)), $urandom());
                default: drive_bus(to_vertex, 1'b1, `VP_CORE_ID, tx_q.pop_front());
            endcase
        end
        @(posedge clk);
        drive_bus(to_vertex, 1'b0, 7'd0, 32'sh0);
    endtask

    task automatic wait_request(input bit on_vertex);
        do begin
            @(negedge clk);
        end while (!(on_vertex ? vertex_request : matrix_request));
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles     <= cycles + 1;
        armed      <= 1'b1;
        started    <= started | start_render;
        exp_mreq   <= start_render;
        exp_mrd    <= 1'b0;
        exp_vrd    <= 1'b0;
        first_vreq <= matrix_read_done;
        if (start_render) begin
            exp_op <= `VP_OP_MODELVIEW;
        end
        if (matrix_request) begin
            m_wait <= 1'b1;
            m_cnt  <= 0;
        end else if (m_wait && matrix_valid && matrix_target_core_id == `VP_CORE_ID) begin
            m_cnt <= m_cnt + 1;
            if (m_cnt == `VP_MATRIX_WORDS - 1) begin
                m_wait  <= 1'b0;
                exp_mrd <= 1'b1;
            end
        end
        if (vertex_request) begin
            v_wait <= 1'b1;
            v_cnt  <= 0;
        end else if (v_wait && vertex_valid && vertex_target_core_id == `VP_CORE_ID) begin
            v_cnt <= v_cnt + 1;
            if (v_cnt == `VP_FACE_WORDS - 1) begin
                v_wait  <= 1'b0;
                exp_vrd <= 1'b1;
            end
        end
        if (vertex_request) begin
            rx <= 1'b1;
        end else if (vertex_read_done) begin
            rx <= 1'b0;
        end
        if (vertex_read_done) begin
            pend <= 1'b1;  // Face in compute
        end else if (vertex_output_valid || vertex_request) begin
            pend <= 1'b0;
        end
        if (vertex_output_valid) begin
            n_valid <= n_valid + 1;
        end
        if (cycles == CYCLE_LIMIT) begin
            stop_run($sformatf("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    a_idle: assert property (@(posedge clk) armed && !started |->
            !(matrix_request || vertex_request || matrix_read_done || vertex_read_done
              || vertex_output_valid) && matrix_opcode == 3'd0)
        else stop_run("A control output was active before start_render");
    a_mreq: assert property (@(posedge clk) armed |-> matrix_request == exp_mreq)
        else report_mismatch("matrix_request", $sampled(exp_mreq), $sampled(matrix_request));
    a_mop: assert property (@(posedge clk) armed |-> matrix_opcode == exp_op)
        else report_mismatch("matrix_opcode", $sampled(exp_op), $sampled(matrix_opcode));
    a_mrd: assert property (@(posedge clk) armed |-> matrix_read_done == exp_mrd)
        else report_mismatch("matrix_read_done", $sampled(exp_mrd), $sampled(matrix_read_done));
    a_vrd: assert property (@(posedge clk) armed |-> vertex_read_done == exp_vrd)
        else report_mismatch("vertex_read_done", $sampled(exp_vrd), $sampled(vertex_read_done));
    a_vreq_first: assert property (@(posedge clk) first_vreq |-> vertex_request)
        else report_mismatch("vertex_request", 1'b1, $sampled(vertex_request));
    a_vreq_rx: assert property (@(posedge clk) vertex_request |-> !rx)
        else stop_run("vertex_request came again while a face was still being received");
    a_missing: assert property (@(posedge clk) vertex_request |-> !(pend && face_front[cur_face]))
        else stop_run($sformatf("Front-facing face %0d produced no output",
                                $sampled(cur_face)));
    a_unexpected: assert property (@(posedge clk)
            vertex_output_valid |-> pend && face_front[cur_face])
        else stop_run($sformatf("Unexpected output pulse for face %0d",
                                $sampled(cur_face)));
    a_view: assert property (@(posedge clk)
            vertex_output_valid |-> view_vert == exp_view[cur_face])
        else report_mismatch("view_vert", $sampled(exp_view[cur_face]), $sampled(view_vert));
    a_uv: assert property (@(posedge clk) vertex_output_valid |-> uv == face_uv[cur_face])
        else report_mismatch("uv", $sampled(face_uv[cur_face]), $sampled(uv));

    initial begin
        rst_n                 = 1'b0;
        start_render          = 1'b0;
        matrix_data           = 32'sh0;
        matrix_target_core_id = 7'd0;
        matrix_valid          = 1'b0;
        vertex_data           = 32'sh0;
        vertex_target_core_id = 7'd0;
        vertex_valid          = 1'b0;
        void'($urandom(SEED));
        build_stimulus();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        start_render <= 1'b1;
        @(posedge clk);
        start_render <= 1'b0;
        wait_request(1'b0);
        for (int i = 0; i < `VP_MATRIX_WORDS; i++) begin
            tx_q.push_back(mat[i]);  // Row-major
        end
        send_stream(1'b0);
        for (int f = 0; f < N_FACES; f++) begin
            wait_request(1'b1);
            cur_face <= f;
            queue_face(f);
            send_stream(1'b1);
        end
        wait_request(1'b1);  // Last face resolved
        repeat (4) @(posedge clk);
        if (n_valid == N_FRONT) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_mismatch("vertex_output_valid count", N_FRONT, n_valid);
        end
    end

endmodule

// File: sources.f
+incdir+logic
logic/vp_pkg.sv
logic/xform_if.sv
logic/matrix_loader.sv
logic/face_receiver.sv
logic/view_transform.sv
logic/cull_unit.sv
logic/vertex_sequencer.sv
logic/vertex_processor.sv
dv/tb_clk_gen.sv
dv/vertex_processor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vertex processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module vertex_processor_tb \
    -f sources.f -o vp_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vp_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "PASS"
exit 0
